// ==== hdl/core_cfg_regs.sv ====
////////////////////////////////////////
// configuration registers
// start, dequeue limit, task counters,
// register bus readback
////////////////////////////////////////

`timescale 1ns/1ps

module core_cfg_regs import task_unit_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  logic        reg_wvalid,
   input  reg_wr_t     reg_wr,
   input  logic        reg_arvalid,
   input  reg_addr_t   reg_araddr,
   output logic        reg_rvalid,
   output word_t       reg_rdata,

   input  logic        deq_done,
   input  logic        enq_done,
   input  ctrl_state_t state,
   output logic        deq_allowed
);

   logic  start;
   word_t deq_remaining;
   word_t num_enq;
   word_t num_deq;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         start <= 1'b0;
      end else if (reg_wvalid & (reg_wr.addr == REG_START)) begin
         start <= reg_wr.data[0];
      end
   end

   // all ones means effectively no limit
   always_ff @(posedge clk) begin
      if (!rstn) begin
         deq_remaining <= '1;
      end else if (reg_wvalid & (reg_wr.addr == REG_N_DEQUEUES)) begin
         deq_remaining <= reg_wr.data;
      end else if (deq_done) begin
         deq_remaining <= deq_remaining - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         num_enq <= '0;
         num_deq <= '0;
      end else begin
         if (enq_done) num_enq <= num_enq + 1'b1;
         if (deq_done) num_deq <= num_deq + 1'b1;
      end
   end

   assign deq_allowed = start & (deq_remaining != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            REG_START:      reg_rdata <= word_t'(start);
            REG_N_DEQUEUES: reg_rdata <= deq_remaining;
            REG_NUM_ENQ:    reg_rdata <= num_enq;
            REG_NUM_DEQ:    reg_rdata <= num_deq;
            REG_STATE:      reg_rdata <= word_t'(state);
            default:        reg_rdata <= '0;
         endcase
      end
   end

endmodule

// ==== hdl/core_ctrl.sv ====
////////////////////////////////////////
// task unit controller
// command decode, dequeue and finish FSM,
// running slot and child count
////////////////////////////////////////

`timescale 1ns/1ps

module core_ctrl import task_unit_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  logic        cmd_valid,
   input  dbus_cmd_t   cmd,
   output logic        cmd_ready,

   input  logic        deq_allowed,
   input  logic        enq_busy,

   output logic        task_arvalid,
   input  logic        task_rvalid,
   input  cq_slot_t    task_rslot,
   input  logic        task_wready,

   output logic        start_task_valid,
   input  logic        start_task_ready,
   output logic        finish_task_valid,
   input  logic        finish_task_ready,
   output cq_slot_t    cq_slot,
   output child_id_t   num_children,

   output logic        field_we,
   output field_sel_t  field_sel,
   output logic        launch,
   output ts_t         launch_ts,

   output logic        deq_done,
   output logic        read_accept,
   output word_t       read_addr,
   output logic        rsp_en,
   output ctrl_state_t state
);

   ctrl_state_t state_next;
   logic        field_hit;
   field_sel_t  field_dec;
   logic        finish_hs;

   assign task_arvalid      = (state == NEXT_TASK) & deq_allowed;
   assign deq_done          = task_arvalid & task_rvalid;
   assign start_task_valid  = (state == INFORM_CQ);
   // hold off finish until the last enqueue has left
   assign finish_task_valid = (state == FINISH_TASK) & !enq_busy;
   assign finish_hs         = finish_task_valid & finish_task_ready;
   assign rsp_en            = (state == IO_READ);
   assign launch_ts         = cmd.data;
   assign read_addr         = cmd.addr;

   // which staged field a write targets
   always_comb begin
      field_hit = 1'b1;
      field_dec = FLD_OBJECT;
      case (cmd.addr)
         ADDR_TASK_OBJECT: field_dec = FLD_OBJECT;
         ADDR_TASK_TTYPE:  field_dec = FLD_TTYPE;
         ADDR_TASK_ARG0:   field_dec = FLD_ARG0;
         ADDR_TASK_ARG1:   field_dec = FLD_ARG1;
         default:          field_hit = 1'b0;
      endcase
   end

   always_comb begin
      state_next  = state;
      cmd_ready   = 1'b0;
      field_we    = 1'b0;
      field_sel   = field_dec;
      launch      = 1'b0;
      read_accept = 1'b0;
      if (cmd_valid & cmd.wr) begin
         if (field_hit) begin
            field_we  = !enq_busy;
            cmd_ready = !enq_busy;
         end else if (cmd.addr == ADDR_DEQ_TASK) begin
            // timestamp write sends the staged task
            launch    = !enq_busy;
            cmd_ready = !enq_busy;
         end else if (cmd.addr == ADDR_FINISH_TASK) begin
            cmd_ready = finish_hs;
            if (state == WAIT_CORE) begin
               state_next = FINISH_TASK;
            end
         end else begin
            // unmapped write, acked and dropped
            cmd_ready = 1'b1;
         end
      end else if (cmd_valid & (state == WAIT_CORE)) begin
         cmd_ready   = 1'b1;
         read_accept = 1'b1;
         state_next  = (cmd.addr == ADDR_DEQ_TASK) ? NEXT_TASK : IO_READ;
      end

      case (state)
         NEXT_TASK:   if (deq_done) state_next = INFORM_CQ;
         INFORM_CQ:   if (start_task_ready) state_next = IO_READ;
         IO_READ:     state_next = WAIT_CORE;
         FINISH_TASK: if (finish_hs) state_next = WAIT_CORE;
         default:     ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= WAIT_CORE;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (deq_done) begin
         cq_slot <= task_rslot;
      end
   end

   // children enqueued by the running task
   always_ff @(posedge clk) begin
      if (!rstn) begin
         num_children <= '0;
      end else if (deq_done) begin
         num_children <= '0;
      end else if (enq_busy & task_wready) begin
         num_children <= num_children + 1'b1;
      end
   end

endmodule

// ==== hdl/core_resp.sv ====
////////////////////////////////////////
// core read response
// dequeued task latch, cycle counter,
// response word select
////////////////////////////////////////

`timescale 1ns/1ps

module core_resp import task_unit_pkg::*; (
   input  logic  clk,
   input  logic  rstn,

   input  logic  deq_done,
   input  task_t task_rdata,
   input  logic  read_accept,
   input  word_t read_addr,
   input  logic  rsp_en,

   output logic  rsp_valid,
   output word_t rsp_data
);

   task_t task_q;
   word_t addr_q;
   word_t cur_cycle;

   always_ff @(posedge clk) begin
      if (deq_done) begin
         task_q <= task_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (read_accept) begin
         addr_q <= read_addr;
      end
   end

   // free running, wraps around
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_cycle <= '0;
      end else begin
         cur_cycle <= cur_cycle + 1'b1;
      end
   end

   assign rsp_valid = rsp_en;

   always_comb begin
      case (addr_q)
         ADDR_DEQ_TASK:    rsp_data = task_q.ts;
         ADDR_TASK_OBJECT: rsp_data = task_q.object;
         ADDR_TASK_TTYPE:  rsp_data = word_t'(task_q.ttype);
         ADDR_TASK_ARG0:   rsp_data = task_q.args[31:0];
         ADDR_TASK_ARG1:   rsp_data = task_q.args[63:32];
         ADDR_CUR_CYCLE:   rsp_data = cur_cycle;
         ADDR_CORE_ID:     rsp_data = CORE_ID_VALUE;
         // unmapped reads come back as zero
         default:          rsp_data = '0;
      endcase
   end

endmodule

// ==== hdl/task_enq_stage.sv ====
////////////////////////////////////////
// enqueue staging registers
// field writes, launch and queue handshake
////////////////////////////////////////

`timescale 1ns/1ps

module task_enq_stage import task_unit_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       field_we,
   input  field_sel_t field_sel,
   input  word_t      field_data,
   input  logic       launch,
   input  ts_t        launch_ts,

   output logic       task_wvalid,
   output task_t      task_wdata,
   input  logic       task_wready,
   output logic       enq_done
);

   ts_t     ts_q;
   object_t object_q;
   ttype_t  ttype_q;
   args_t   args_q;

   // field writes are held off by the controller while task_wvalid is high
   always_ff @(posedge clk) begin
      if (field_we) begin
         case (field_sel)
            FLD_OBJECT: object_q     <= field_data;
            FLD_TTYPE:  ttype_q      <= field_data[3:0];
            FLD_ARG0:   args_q[31:0] <= field_data;
            FLD_ARG1:   args_q[63:32] <= field_data;
            default:    ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (launch) begin
         ts_q <= launch_ts;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (launch) begin
         task_wvalid <= 1'b1;
      end else if (task_wready) begin
         task_wvalid <= 1'b0;
      end
   end

   always_comb begin
      task_wdata.ts     = ts_q;
      task_wdata.object = object_q;
      task_wdata.ttype  = ttype_q;
      task_wdata.args   = args_q;
   end

   assign enq_done = task_wvalid & task_wready;

endmodule

// ==== hdl/task_unit_core.sv ====
////////////////////////////////////////
// task unit top level
// controller, enqueue stage, response
// path and configuration registers
////////////////////////////////////////

`timescale 1ns/1ps

module task_unit_core import task_unit_pkg::*; (
   input  logic      clk,
   input  logic      rstn,

   // core data bus
   input  logic      cmd_valid,
   input  dbus_cmd_t cmd,
   output logic      cmd_ready,
   output logic      rsp_valid,
   output word_t     rsp_data,

   // task queue
   output logic      task_arvalid,
   input  logic      task_rvalid,
   input  task_t     task_rdata,
   input  cq_slot_t  task_rslot,
   output logic      task_wvalid,
   output task_t     task_wdata,
   input  logic      task_wready,

   // commit queue
   output logic      start_task_valid,
   output cq_slot_t  start_task_slot,
   input  logic      start_task_ready,
   output logic      finish_task_valid,
   output cq_slot_t  finish_task_slot,
   output child_id_t finish_task_num_children,
   input  logic      finish_task_ready,

   // register bus
   input  logic      reg_wvalid,
   input  reg_wr_t   reg_wr,
   input  logic      reg_arvalid,
   input  reg_addr_t reg_araddr,
   output logic      reg_rvalid,
   output word_t     reg_rdata
);

   cq_slot_t    cq_slot;
   logic        field_we;
   field_sel_t  field_sel;
   logic        launch;
   ts_t         launch_ts;
   logic        deq_done;
   logic        enq_done;
   logic        read_accept;
   word_t       read_addr;
   logic        rsp_en;
   logic        deq_allowed;
   ctrl_state_t state;

   // both queues see the slot of the running task
   assign start_task_slot  = cq_slot;
   assign finish_task_slot = cq_slot;

   core_ctrl ctrl_i (
      .clk               (clk),
      .rstn              (rstn),
      .cmd_valid         (cmd_valid),
      .cmd               (cmd),
      .cmd_ready         (cmd_ready),
      .deq_allowed       (deq_allowed),
      .enq_busy          (task_wvalid),
      .task_arvalid      (task_arvalid),
      .task_rvalid       (task_rvalid),
      .task_rslot        (task_rslot),
      .task_wready       (task_wready),
      .start_task_valid  (start_task_valid),
      .start_task_ready  (start_task_ready),
      .finish_task_valid (finish_task_valid),
      .finish_task_ready (finish_task_ready),
      .cq_slot           (cq_slot),
      .num_children      (finish_task_num_children),
      .field_we          (field_we),
      .field_sel         (field_sel),
      .launch            (launch),
      .launch_ts         (launch_ts),
      .deq_done          (deq_done),
      .read_accept       (read_accept),
      .read_addr         (read_addr),
      .rsp_en            (rsp_en),
      .state             (state)
   );

   task_enq_stage enq_i (
      .clk         (clk),
      .rstn        (rstn),
      .field_we    (field_we),
      .field_sel   (field_sel),
      .field_data  (cmd.data),
      .launch      (launch),
      .launch_ts   (launch_ts),
      .task_wvalid (task_wvalid),
      .task_wdata  (task_wdata),
      .task_wready (task_wready),
      .enq_done    (enq_done)
   );

   core_resp resp_i (
      .clk         (clk),
      .rstn        (rstn),
      .deq_done    (deq_done),
      .task_rdata  (task_rdata),
      .read_accept (read_accept),
      .read_addr   (read_addr),
      .rsp_en      (rsp_en),
      .rsp_valid   (rsp_valid),
      .rsp_data    (rsp_data)
   );

   core_cfg_regs cfg_i (
      .clk         (clk),
      .rstn        (rstn),
      .reg_wvalid  (reg_wvalid),
      .reg_wr      (reg_wr),
      .reg_arvalid (reg_arvalid),
      .reg_araddr  (reg_araddr),
      .reg_rvalid  (reg_rvalid),
      .reg_rdata   (reg_rdata),
      .deq_done    (deq_done),
      .enq_done    (enq_done),
      .state       (state),
      .deq_allowed (deq_allowed)
   );

endmodule

// ==== hdl/task_unit_pkg.sv ====
////////////////////////////////////////
// shared definitions of the task unit
// data-bus address map, register map,
// task and bus types, controller states
////////////////////////////////////////

package task_unit_pkg;

   // basic widths
   typedef logic [31:0] word_t;
   typedef logic [31:0] ts_t;
   typedef logic [31:0] object_t;
   typedef logic [3:0]  ttype_t;
   typedef logic [5:0]  cq_slot_t;
   typedef logic [7:0]  child_id_t;
   typedef logic [7:0]  reg_addr_t;

   localparam int ARG_WORDS = 2;
   typedef logic [ARG_WORDS*32-1:0] args_t;

   // one task as seen by the task queue
   typedef struct packed {
      ts_t     ts;
      object_t object;
      ttype_t  ttype;
      args_t   args;
   } task_t;

   // data-bus command from the core
   typedef struct packed {
      logic  wr;
      word_t addr;
      word_t data;
   } dbus_cmd_t;

   // register bus write
   typedef struct packed {
      reg_addr_t addr;
      word_t     data;
   } reg_wr_t;

   typedef enum logic [2:0] {
      WAIT_CORE,
      NEXT_TASK,
      INFORM_CQ,
      IO_READ,
      FINISH_TASK
   } ctrl_state_t;

   typedef enum logic [1:0] {
      FLD_OBJECT,
      FLD_TTYPE,
      FLD_ARG0,
      FLD_ARG1
   } field_sel_t;

   // data-bus address map
   localparam word_t ADDR_DEQ_TASK    = 32'hc000_0000;
   localparam word_t ADDR_TASK_OBJECT = 32'hc000_0004;
   localparam word_t ADDR_TASK_TTYPE  = 32'hc000_0008;
   localparam word_t ADDR_TASK_ARG0   = 32'hc000_000c;
   localparam word_t ADDR_TASK_ARG1   = 32'hc000_0010;
   localparam word_t ADDR_FINISH_TASK = 32'hc000_0014;
   localparam word_t ADDR_CUR_CYCLE   = 32'hc000_0020;
   localparam word_t ADDR_CORE_ID     = 32'hc000_0024;

   // configuration register map
   localparam reg_addr_t REG_START      = 8'h00;
   localparam reg_addr_t REG_N_DEQUEUES = 8'h04;
   localparam reg_addr_t REG_NUM_ENQ    = 8'h08;
   localparam reg_addr_t REG_NUM_DEQ    = 8'h0c;
   localparam reg_addr_t REG_STATE      = 8'h10;

   localparam word_t CORE_ID_VALUE = 32'h0000_0003;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the task unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_task_unit -f verilog.f -o sim_tb \
   > build.log 2>&1 \
   && ./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL (see build.log and sim.log)"; exit 1; }

// ==== verif/task_unit_props.sv ====
////////////////////////////////////////
// concurrent properties of the task unit
// reset state, enqueue hold, finish ack,
// register read latency
////////////////////////////////////////

`timescale 1ns/1ps

module task_unit_props import task_unit_pkg::*; (
   input logic      clk,
   input logic      rstn,
   input logic      cmd_valid,
   input dbus_cmd_t cmd,
   input logic      cmd_ready,
   input logic      rsp_valid,
   input logic      task_arvalid,
   input logic      task_wvalid,
   input task_t     task_wdata,
   input logic      task_wready,
   input logic      start_task_valid,
   input logic      finish_task_valid,
   input logic      finish_task_ready,
   input logic      reg_arvalid,
   input logic      reg_rvalid
);

   // read by the testbench for its closing count
   int unsigned fail_count = 0;

   // every outgoing valid is low right after a reset cycle
   reset_quiet: assert property (@(posedge clk)
      !rstn |=> !rsp_valid && !task_arvalid && !task_wvalid &&
                !start_task_valid && !finish_task_valid && !reg_rvalid)
      else begin
         fail_count++;
         $error("a valid output is high after reset");
      end

   // enqueue stays put until the queue takes it
   enq_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_wvalid && !task_wready |=> task_wvalid && $stable(task_wdata))
      else begin
         fail_count++;
         $error("task_wvalid or task_wdata changed before task_wready");
      end

   // the finish write is acked only by the commit queue handshake
   finish_ack: assert property (@(posedge clk) disable iff (!rstn)
      cmd_valid && cmd.wr && (cmd.addr == ADDR_FINISH_TASK) && cmd_ready
      |-> finish_task_valid && finish_task_ready)
      else begin
         fail_count++;
         $error("finish write acked without the finish handshake");
      end

   reg_read_lat: assert property (@(posedge clk) disable iff (!rstn)
      reg_arvalid |=> reg_rvalid)
      else begin
         fail_count++;
         $error("reg_rvalid missing one cycle after reg_arvalid");
      end

endmodule

bind task_unit_core task_unit_props props_i (.*);

// ==== verif/tb_task_unit.sv ====
////////////////////////////////////////
// testbench of the task unit
// core, task queue and commit queue models,
// checks, watchdog and closing report
////////////////////////////////////////

`timescale 1ns/1ps

module tb_task_unit import task_unit_pkg::*; ();

   logic      clk;
   logic      rstn;
   logic      cmd_valid;
   dbus_cmd_t cmd;
   logic      cmd_ready;
   logic      rsp_valid;
   word_t     rsp_data;
   logic      task_arvalid;
   logic      task_rvalid;
   task_t     task_rdata;
   cq_slot_t  task_rslot;
   logic      task_wvalid;
   task_t     task_wdata;
   logic      task_wready;
   logic      start_task_valid;
   cq_slot_t  start_task_slot;
   logic      start_task_ready;
   logic      finish_task_valid;
   cq_slot_t  finish_task_slot;
   child_id_t finish_task_num_children;
   logic      finish_task_ready;
   logic      reg_wvalid;
   reg_wr_t   reg_wr;
   logic      reg_arvalid;
   reg_addr_t reg_araddr;
   logic      reg_rvalid;
   word_t     reg_rdata;

   int        errors = 0;
   // model of the queues and of the staged task
   task_t     exp_task;
   task_t     last_task;
   cq_slot_t  last_slot;
   int        enq_count = 0;
   int        rd_delay = 0;
   logic      start_set = 1'b0;
   word_t     deq_left = '1;
   logic      prev_wvalid = 1'b0;
   logic      prev_wready = 1'b0;
   task_t     prev_wdata;
   word_t     rd;
   word_t     cyc0;
   word_t     cyc1;

   task_unit_core dut_i (.*);

   always #10 clk = ~clk;

   task automatic check_word(input string name, input word_t exp, input word_t act);
      assert (act === exp) else begin
         errors++;
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_task(input string name, input task_t exp, input task_t act);
      assert (act === exp) else begin
         errors++;
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   function automatic task_t random_task();
      task_t t;
      t.ts     = $urandom;
      t.object = $urandom;
      t.ttype  = 4'($urandom_range(0, 15));
      t.args   = {$urandom, $urandom};
      return t;
   endfunction

   task automatic wait_cmd_ready();
      do @(posedge clk); while (cmd_ready !== 1'b1);
   endtask

   task automatic core_read(input word_t addr, output word_t data);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd.wr    = 1'b0;
      cmd.addr  = addr;
      cmd.data  = '0;
      wait_cmd_ready();
      @(negedge clk);
      cmd_valid = 1'b0;
      if (addr == ADDR_DEQ_TASK) begin
         do @(posedge clk); while (rsp_valid !== 1'b1);
      end else begin
         @(posedge clk);
         check_word("rsp_valid", 32'd1, word_t'(rsp_valid));
      end
      data = rsp_data;
   endtask

   task automatic core_write(input word_t addr, input word_t data);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd.wr    = 1'b1;
      cmd.addr  = addr;
      cmd.data  = data;
      wait_cmd_ready();
      case (addr)
         ADDR_TASK_OBJECT: exp_task.object = data;
         ADDR_TASK_TTYPE:  exp_task.ttype = data[3:0];
         ADDR_TASK_ARG0:   exp_task.args[31:0] = data;
         ADDR_TASK_ARG1:   exp_task.args[63:32] = data;
         ADDR_DEQ_TASK:    exp_task.ts = data;
         default:          ;
      endcase
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic reg_write(input reg_addr_t addr, input word_t data);
      @(negedge clk);
      reg_wvalid   = 1'b1;
      reg_wr.addr  = addr;
      reg_wr.data  = data;
      if (addr == REG_START) start_set = data[0];
      if (addr == REG_N_DEQUEUES) deq_left = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t addr, output word_t data);
      @(negedge clk);
      reg_arvalid = 1'b1;
      reg_araddr  = addr;
      @(negedge clk);
      reg_arvalid = 1'b0;
      @(posedge clk);
      check_word("reg_rvalid", 32'd1, word_t'(reg_rvalid));
      data = reg_rdata;
   endtask

   task automatic enqueue_one();
      core_write(ADDR_TASK_OBJECT, $urandom);
      core_write(ADDR_TASK_TTYPE, $urandom_range(0, 15));
      core_write(ADDR_TASK_ARG0, $urandom);
      core_write(ADDR_TASK_ARG1, $urandom);
      core_write(ADDR_DEQ_TASK, $urandom);
   endtask

   task automatic dequeue_and_check();
      core_read(ADDR_DEQ_TASK, rd);
      check_word("rsp_data ts", last_task.ts, rd);
   endtask

   // task queue and commit queue, with random ready delays
   always @(negedge clk) begin
      if (task_rvalid) begin
         task_rvalid = 1'b0;
      end else if (rstn && task_arvalid) begin
         if (rd_delay > 0) begin
            rd_delay--;
         end else begin
            last_task   = random_task();
            last_slot   = 6'($urandom);
            task_rdata  = last_task;
            task_rslot  = last_slot;
            task_rvalid = 1'b1;
            rd_delay    = $urandom_range(0, 3);
         end
      end
      task_wready       = task_wvalid && ($urandom_range(0, 2) == 0);
      start_task_ready  = start_task_valid && ($urandom_range(0, 1) == 0);
      finish_task_ready = finish_task_valid && ($urandom_range(0, 1) == 0);
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (task_wvalid) check_task("task_wdata", exp_task, task_wdata);
         if (prev_wvalid && !prev_wready) begin
            check_word("task_wvalid", 32'd1, word_t'(task_wvalid));
            check_task("task_wdata held", prev_wdata, task_wdata);
         end
         assert (!task_arvalid || (start_set && deq_left != 0)) else begin
            errors++;
            $display("task_arvalid went high while dequeues were not allowed at %0t", $time);
         end
         if (start_task_valid) begin
            check_word("start_task_slot", word_t'(last_slot), word_t'(start_task_slot));
         end
         if (finish_task_valid && finish_task_ready) begin
            check_word("finish_task_num_children", enq_count,
                       word_t'(finish_task_num_children));
            check_word("finish_task_slot", word_t'(last_slot), word_t'(finish_task_slot));
         end
         if (task_arvalid && task_rvalid) begin
            enq_count = 0;
            deq_left  = deq_left - 1;
         end else if (task_wvalid && task_wready) begin
            enq_count++;
         end
      end
      prev_wvalid = task_wvalid;
      prev_wready = task_wready;
      prev_wdata  = task_wdata;
   end

   // 6 scenarios, 200 cycles each, 20 ns per cycle
   initial begin
      #(6 * 200 * 20);
      $display("timeout: the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h7ef3));
      clk = 1'b0;
      rstn = 1'b0;
      cmd_valid = 1'b0;
      cmd = '0;
      task_rvalid = 1'b0;
      task_rdata = '0;
      task_rslot = '0;
      task_wready = 1'b0;
      start_task_ready = 1'b0;
      finish_task_ready = 1'b0;
      reg_wvalid = 1'b0;
      reg_wr = '0;
      reg_arvalid = 1'b0;
      reg_araddr = '0;
      repeat (8) @(negedge clk);
      rstn = 1'b1;
      @(posedge clk);
      check_word("rsp_valid", 32'd0, word_t'(rsp_valid));
      check_word("task_arvalid", 32'd0, word_t'(task_arvalid));
      check_word("task_wvalid", 32'd0, word_t'(task_wvalid));
      check_word("start_task_valid", 32'd0, word_t'(start_task_valid));
      check_word("finish_task_valid", 32'd0, word_t'(finish_task_valid));
      check_word("reg_rvalid", 32'd0, word_t'(reg_rvalid));

      // first dequeue waits until the unit is started
      reg_write(REG_N_DEQUEUES, 32'd2);
      fork
         dequeue_and_check();
         begin
            repeat (20) @(negedge clk);
            reg_write(REG_START, 32'd1);
         end
      join
      core_read(ADDR_TASK_OBJECT, rd);
      check_word("rsp_data object", last_task.object, rd);
      core_read(ADDR_TASK_TTYPE, rd);
      check_word("rsp_data ttype", word_t'(last_task.ttype), rd);
      core_read(ADDR_TASK_ARG0, rd);
      check_word("rsp_data arg0", last_task.args[31:0], rd);
      core_read(ADDR_TASK_ARG1, rd);
      check_word("rsp_data arg1", last_task.args[63:32], rd);
      core_read(32'hc000_0100, rd);
      check_word("rsp_data unmapped", 32'd0, rd);

      repeat (3) enqueue_one();
      core_write(ADDR_FINISH_TASK, 32'd0);
      dequeue_and_check();
      enqueue_one();
      core_write(ADDR_FINISH_TASK, 32'd0);
      reg_read(REG_NUM_DEQ, rd);
      check_word("reg_rdata num_deq", 32'd2, rd);

      // limit reached, the third dequeue stalls until the limit is raised
      fork
         dequeue_and_check();
         begin
            repeat (30) @(negedge clk);
            reg_write(REG_N_DEQUEUES, 32'd1);
         end
      join
      core_write(ADDR_FINISH_TASK, 32'd0);

      core_read(ADDR_CORE_ID, rd);
      check_word("rsp_data core_id", CORE_ID_VALUE, rd);
      core_read(ADDR_CUR_CYCLE, cyc0);
      core_read(ADDR_CUR_CYCLE, cyc1);
      assert (cyc1 > cyc0) else begin
         errors++;
         $display("cycle counter did not increase between two reads at %0t", $time);
      end

      repeat (5) @(negedge clk);
      $display("errors: %0d in checks, %0d in properties",
               errors, dut_i.props_i.fail_count);
      if (errors == 0 && dut_i.props_i.fail_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
hdl/task_unit_pkg.sv
hdl/core_ctrl.sv
hdl/task_enq_stage.sv
hdl/core_resp.sv
hdl/core_cfg_regs.sv
hdl/task_unit_core.sv
verif/task_unit_props.sv
verif/tb_task_unit.sv
